/* vlog.f */
+incdir+design
design/ifu_pkg.sv
design/nano_btb.sv
design/fetch_credit.sv
design/fetch_pc.sv
design/ifu_top.sv
dv/ifu_tb.sv

/* dv/ifu_tb.sv */
/*
 * instruction fetch unit testbench
 * random grants, credits, flushes and btb updates checked against a model
 */
`include "ifu_params.svh"

module ifu_tb;

  import ifu_pkg::*;

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 8;
  localparam int NUM_CYCLES   = 4000;
  localparam int TIMEOUT      = 2 * NUM_CYCLES * CLK_PERIOD;
  localparam int N            = `IFU_NUM_NBTB;
  localparam int AW           = `IFU_BTB_PC_W;

  logic       clk;
  logic       resetn;
  logic       flush;
  pc_t        branch_pc;
  logic       gnt;
  logic       req;
  slot_mask_t slots;
  pc_t        addr;
  credit_t    credit_ret;
  logic       upd_v;
  btb_pc_t    upd_pc;
  btb_pc_t    upd_tgt;
  logic       upd_valid;

  // reference model state
  pc_t     m_pc;
  int      m_credit;
  logic    m_vld    [N];
  btb_pc_t m_btb_pc [N];
  btb_pc_t m_tgt    [N];
  int      m_ptr;
  int      seed_val;

  ifu_top ifu_top_i (
    .clk             (clk),
    .resetn          (resetn),
    .flush_i         (flush),
    .branch_pc_i     (branch_pc),
    .instr_gnt_i     (gnt),
    .instr_req_o     (req),
    .instr_slots_o   (slots),
    .instr_addr_o    (addr),
    .credit_return_i (credit_ret),
    .btb_upd_v_i     (upd_v),
    .btb_upd_pc_i    (upd_pc),
    .btb_upd_tgt_i   (upd_tgt),
    .btb_upd_valid_i (upd_valid)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_pc(input string name, input pc_t exp, input pc_t act);
    if (exp !== act) begin
      abort_run($sformatf("CHECK FAILED %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_slots(input string name, input slot_mask_t exp, input slot_mask_t act);
    if (exp !== act) begin
      abort_run($sformatf("CHECK FAILED %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  task automatic check_req(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      abort_run($sformatf("CHECK FAILED %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  // slot 0 is the word at m_pc, slot 1 the word after it within the pair
  task automatic model_lookup(output logic h0, output btb_pc_t t0,
                              output logic h1, output btb_pc_t t1);
    logic [AW-3:0] word0;
    logic [AW-3:0] word1;
    word0 = m_pc[AW-1:2];
    word1 = word0 + 1'b1;
    h0 = 1'b0;
    h1 = 1'b0;
    t0 = '0;
    t1 = '0;
    for (int i = 0; i < N; i++) begin
      if (m_vld[i] && m_btb_pc[i][AW-1:2] == word0) begin
        h0 = 1'b1;
        t0 = m_tgt[i];
      end
      if (m_vld[i] && !m_pc[2] && m_btb_pc[i][AW-1:2] == word1) begin
        h1 = 1'b1;
        t1 = m_tgt[i];
      end
    end
  endtask

  function automatic slot_mask_t model_slots(input logic exp_req, input logic h0);
    if (!exp_req) begin
      return 2'b00;
    end
    return (m_pc[2] || h0) ? 2'b01 : 2'b11;
  endfunction

  // advance the model by one clock edge with the inputs seen at that edge
  task automatic model_step();
    logic       h0;
    logic       h1;
    btb_pc_t    t0;
    btb_pc_t    t1;
    logic       exp_req;
    slot_mask_t sl;
    logic       done;
    int         spent;
    int         match;
    pc_t        nxt;
    model_lookup(h0, t0, h1, t1);
    exp_req = (m_credit >= 2) && !flush;
    sl = model_slots(exp_req, h0);
    done = exp_req && gnt;
    spent = done ? int'(sl[0]) + int'(sl[1]) : 0;
    if (flush) begin
      nxt = branch_pc;
    end else if (done && h0) begin
      nxt = pc_t'(t0);
    end else if (done && sl[1] && h1) begin
      nxt = pc_t'(t1);
    end else if (done) begin
      nxt = m_pc + (m_pc[2] ? 4 : 8);
    end else begin
      nxt = m_pc;
    end
    m_pc = nxt & ~pc_t'(3);
    m_credit = m_credit - spent + int'(credit_ret);
    if (upd_v) begin
      match = -1;
      for (int i = 0; i < N; i++) begin
        if (m_vld[i] && m_btb_pc[i][AW-1:2] == upd_pc[AW-1:2]) begin
          match = i;
        end
      end
      if (match < 0) begin
        match = m_ptr;
        m_ptr = (m_ptr + 1) % N;
      end
      m_vld[match] = upd_valid;
      m_btb_pc[match] = upd_pc;
      m_tgt[match] = upd_tgt;
    end
  endtask

  task automatic drive_random();
    int      outstanding;
    int      max_ret;
    int      off;
    btb_pc_t base;
    outstanding = `IFU_IQ_DEPTH - m_credit;
    max_ret = (outstanding < 2) ? outstanding : 2;
    gnt <= ($urandom % 4) != 0;
    // return nothing half the time so the queue fills up
    if ($urandom % 2) begin
      credit_ret <= credit_t'($urandom % (max_ret + 1));
    end else begin
      credit_ret <= '0;
    end
    flush <= ($urandom % 100) < 3;
    branch_pc <= $urandom & 32'h0000_ffff;
    // updates land on the 16 words around the running address
    base = m_pc[AW-1:0] & ~btb_pc_t'(3);
    off = int'($urandom % 16) - 8;
    upd_v <= ($urandom % 10) == 0;
    upd_pc <= base + btb_pc_t'(off * 4);
    upd_tgt <= btb_pc_t'($urandom);
    upd_valid <= ($urandom % 4) != 0;
  endtask

  initial begin
    logic       h0;
    logic       h1;
    btb_pc_t    t0;
    btb_pc_t    t1;
    logic       exp_req;
    int         dut_outstanding;
    clk = 1'b0;
    resetn = 1'b0;
    flush = 1'b0;
    branch_pc = '0;
    gnt = 1'b0;
    credit_ret = '0;
    upd_v = 1'b0;
    upd_pc = '0;
    upd_tgt = '0;
    upd_valid = 1'b0;
    seed_val = $urandom(32'h3870);
    m_pc = `IFU_RESET_PC;
    m_credit = `IFU_IQ_DEPTH;
    m_ptr = 0;
    dut_outstanding = 0;
    for (int i = 0; i < N; i++) begin
      m_vld[i] = 1'b0;
      m_btb_pc[i] = '0;
      m_tgt[i] = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    resetn <= 1'b1;
    for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
      // outputs are settled mid cycle
      @(negedge clk);
      model_lookup(h0, t0, h1, t1);
      exp_req = (m_credit >= 2) && !flush;
      check_req($sformatf("cycle %0d instr_req_o", cyc), exp_req, req);
      check_slots($sformatf("cycle %0d instr_slots_o", cyc), model_slots(exp_req, h0), slots);
      check_pc($sformatf("cycle %0d instr_addr_o", cyc), m_pc, addr);
      // slots the DUT has fetched that the queue has not handed back yet
      if (req && gnt) begin
        dut_outstanding = dut_outstanding + int'(slots[0]) + int'(slots[1]);
      end
      if (dut_outstanding > `IFU_IQ_DEPTH) begin
        abort_run("the DUT fetched more slots than the instruction queue has free");
      end
      dut_outstanding = dut_outstanding - int'(credit_ret);
      @(posedge clk);
      model_step();
      drive_random();
    end
    $display("Everything OK");
    $finish;
  end

  initial begin
    #(TIMEOUT);
    abort_run("watchdog expired before the stimulus finished");
  end

endmodule

/* design/ifu_top.sv */
/*
 * instruction fetch unit top level
 * address generation, queue credits and nano btb
 */
module ifu_top (
  input  logic                clk,
  input  logic                resetn,
  input  logic                flush_i,
  input  ifu_pkg::pc_t        branch_pc_i,
  input  logic                instr_gnt_i,
  output logic                instr_req_o,
  output ifu_pkg::slot_mask_t instr_slots_o,
  output ifu_pkg::pc_t        instr_addr_o,
  input  ifu_pkg::credit_t    credit_return_i,
  input  logic                btb_upd_v_i,
  input  ifu_pkg::btb_pc_t    btb_upd_pc_i,
  input  ifu_pkg::btb_pc_t    btb_upd_tgt_i,
  input  logic                btb_upd_valid_i
);

  import ifu_pkg::*;

  logic    fetch_ok;
  logic    req_done;
  logic    hit0;
  logic    hit1;
  btb_pc_t tgt0;
  btb_pc_t tgt1;

  fetch_pc fetch_pc_i (
    .clk           (clk),
    .resetn        (resetn),
    .flush_i       (flush_i),
    .branch_pc_i   (branch_pc_i),
    .instr_gnt_i   (instr_gnt_i),
    .fetch_ok_i    (fetch_ok),
    .hit0_i        (hit0),
    .tgt0_i        (tgt0),
    .hit1_i        (hit1),
    .tgt1_i        (tgt1),
    .instr_req_o   (instr_req_o),
    .instr_slots_o (instr_slots_o),
    .instr_addr_o  (instr_addr_o),
    .req_done_o    (req_done)
  );

  fetch_credit fetch_credit_i (
    .clk             (clk),
    .resetn          (resetn),
    .req_done_i      (req_done),
    .slots_i         (instr_slots_o),
    .credit_return_i (credit_return_i),
    .fetch_ok_o      (fetch_ok)
  );

  // lookup on the current fetch pair
  nano_btb nano_btb_i (
    .clk             (clk),
    .resetn          (resetn),
    .lookup_pc_i     (instr_addr_o),
    .btb_upd_v_i     (btb_upd_v_i),
    .btb_upd_pc_i    (btb_upd_pc_i),
    .btb_upd_tgt_i   (btb_upd_tgt_i),
    .btb_upd_valid_i (btb_upd_valid_i),
    .hit0_o          (hit0),
    .tgt0_o          (tgt0),
    .hit1_o          (hit1),
    .tgt1_o          (tgt1)
  );

endmodule

/* design/fetch_pc.sv */
/*
 * fetch address register and request generation
 * next address by flush, then btb prediction, then +4/+8
 */
`include "ifu_params.svh"

module fetch_pc (
  input  logic                clk,
  input  logic                resetn,
  input  logic                flush_i,
  input  ifu_pkg::pc_t        branch_pc_i,
  input  logic                instr_gnt_i,
  input  logic                fetch_ok_i,
  input  logic                hit0_i,
  input  ifu_pkg::btb_pc_t    tgt0_i,
  input  logic                hit1_i,
  input  ifu_pkg::btb_pc_t    tgt1_i,
  output logic                instr_req_o,
  output ifu_pkg::slot_mask_t instr_slots_o,
  output ifu_pkg::pc_t        instr_addr_o,
  output logic                req_done_o
);

  import ifu_pkg::*;

  pc_t addr_q;
  pc_t addr_d;
  pc_t seq_pc;

  assign instr_addr_o = addr_q;

  // no request while redirecting
  assign instr_req_o = fetch_ok_i & ~flush_i;
  assign req_done_o  = instr_req_o & instr_gnt_i;

  // single slot for the upper word, or when slot 0 is a taken branch
  always_comb begin
    if (!instr_req_o) begin
      instr_slots_o = 2'b00;
    end else if (addr_q[2] || hit0_i) begin
      instr_slots_o = 2'b01;
    end else begin
      instr_slots_o = 2'b11;
    end
  end

  assign seq_pc = addr_q + (addr_q[2] ? pc_t'(4) : pc_t'(8));

  always_comb begin
    if (flush_i) begin
      addr_d = branch_pc_i;
    end else if (req_done_o && hit0_i) begin
      addr_d = pc_t'(tgt0_i);
    end else if (req_done_o && instr_slots_o[1] && hit1_i) begin
      addr_d = pc_t'(tgt1_i);
    end else if (req_done_o) begin
      addr_d = seq_pc;
    end else begin
      // hold until granted
      addr_d = addr_q;
    end
  end

  // word aligned fetch address
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      addr_q <= `IFU_RESET_PC;
    end else begin
      addr_q <= {addr_d[`IFU_PC_W-1:2], 2'b00};
    end
  end

endmodule

/* design/fetch_credit.sv */
/*
 * instruction queue credit counter
 * allows a fetch while two queue slots are free
 */
`include "ifu_params.svh"

module fetch_credit (
  input  logic                clk,
  input  logic                resetn,
  input  logic                req_done_i,
  input  ifu_pkg::slot_mask_t slots_i,
  input  ifu_pkg::credit_t    credit_return_i,
  output logic                fetch_ok_o
);

  import ifu_pkg::*;

  credit_t credit_q;
  credit_t spent;

  // one credit per granted slot
  always_comb begin
    spent = '0;
    if (req_done_i) begin
      spent = credit_t'(slots_i[0]) + credit_t'(slots_i[1]);
    end
  end

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      credit_q <= credit_t'(`IFU_IQ_DEPTH);
    end else begin
      credit_q <= credit_q - spent + credit_return_i;
    end
  end

  // room for a full pair, so a two-slot fetch never overruns the queue
  assign fetch_ok_o = (credit_q >= credit_t'(2));

endmodule

/* design/nano_btb.sv */
/*
 * nano btb: small fully associative branch target buffer
 * looks up both slots of a fetch pair in the same cycle,
 * round-robin replacement on a single update port
 */
`include "ifu_params.svh"

module nano_btb (
  input  logic             clk,
  input  logic             resetn,
  input  ifu_pkg::pc_t     lookup_pc_i,
  input  logic             btb_upd_v_i,
  input  ifu_pkg::btb_pc_t btb_upd_pc_i,
  input  ifu_pkg::btb_pc_t btb_upd_tgt_i,
  input  logic             btb_upd_valid_i,
  output logic             hit0_o,
  output ifu_pkg::btb_pc_t tgt0_o,
  output logic             hit1_o,
  output ifu_pkg::btb_pc_t tgt1_o
);

  import ifu_pkg::*;

  localparam int N = `IFU_NUM_NBTB;
  localparam int AW = `IFU_BTB_PC_W;

  btb_pc_t  entry_pc  [N];
  btb_pc_t  entry_tgt [N];
  btb_sel_t entry_vld;

  // one-hot replacement pointer
  btb_sel_t rr_ptr;
  btb_sel_t rr_ptr_next;

  btb_sel_t hit0_vec;
  btb_sel_t hit1_vec;
  btb_sel_t upd_match;
  btb_sel_t upd_sel;

  assign rr_ptr_next = {rr_ptr[N-2:0], rr_ptr[N-1]};

  // compare every entry against both slots of the pair
  always_comb begin
    for (int i = 0; i < N; i++) begin
      hit0_vec[i] = entry_vld[i] &
                    (entry_pc[i][AW-1:2] == lookup_pc_i[AW-1:2]);
      hit1_vec[i] = entry_vld[i] & ~lookup_pc_i[2] &
                    (entry_pc[i][AW-1:2] == {lookup_pc_i[AW-1:3], 1'b1});
    end
  end

  assign hit0_o = |hit0_vec;
  assign hit1_o = |hit1_vec;

  // at most one entry hits, so the targets can be or-ed together
  always_comb begin
    tgt0_o = '0;
    tgt1_o = '0;
    for (int i = 0; i < N; i++) begin
      tgt0_o = tgt0_o | ({AW{hit0_vec[i]}} & entry_tgt[i]);
      tgt1_o = tgt1_o | ({AW{hit1_vec[i]}} & entry_tgt[i]);
    end
  end

  // an update to an address already held rewrites that entry
  always_comb begin
    for (int i = 0; i < N; i++) begin
      upd_match[i] = entry_vld[i] &
                     (entry_pc[i][AW-1:2] == btb_upd_pc_i[AW-1:2]);
    end
  end

  assign upd_sel = (|upd_match) ? upd_match : rr_ptr;

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      entry_vld <= '0;
      rr_ptr    <= btb_sel_t'(1);
    end else if (btb_upd_v_i) begin
      for (int i = 0; i < N; i++) begin
        if (upd_sel[i]) begin
          entry_vld[i] <= btb_upd_valid_i;
        end
      end
      // pointer only moves when a new address takes an entry
      if (!(|upd_match)) begin
        rr_ptr <= rr_ptr_next;
      end
    end
  end

  // entry payload
  always_ff @(posedge clk) begin
    if (btb_upd_v_i) begin
      for (int i = 0; i < N; i++) begin
        if (upd_sel[i]) begin
          entry_pc[i]  <= btb_upd_pc_i;
          entry_tgt[i] <= btb_upd_tgt_i;
        end
      end
    end
  end

endmodule

/* design/ifu_pkg.sv */
/*
 * instruction fetch unit types
 * shared by the RTL and the testbench
 */
`include "ifu_params.svh"

package ifu_pkg;

  // full fetch address
  typedef logic [`IFU_PC_W-1:0]     pc_t;
  // low address bits and targets held in the nano btb
  typedef logic [`IFU_BTB_PC_W-1:0] btb_pc_t;
  typedef logic [`IFU_CREDIT_W-1:0] credit_t;

  // bit 0 is the slot at the fetch address, bit 1 the slot at +4
  typedef logic [1:0]               slot_mask_t;

  // one bit per nano btb entry
  typedef logic [`IFU_NUM_NBTB-1:0] btb_sel_t;

endpackage

/* design/ifu_params.svh */
/*
 * instruction fetch unit sizes and reset address
 */
`ifndef IFU_PARAMS_SVH
`define IFU_PARAMS_SVH

// fetch address and the low bits kept by the nano btb
`define IFU_PC_W      32
`define IFU_BTB_PC_W  16

// nano btb entries, at least 2
`define IFU_NUM_NBTB  4

// instruction queue slots and credit counter width
`define IFU_IQ_DEPTH  4
`define IFU_CREDIT_W  3

`define IFU_RESET_PC  32'h0000_0100

`endif
